//--- logic/loader_macros.svh
`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

// ==============================
// SDRAM geometry
// ==============================
`define SDRAM_ADDR_W 25
`define SDRAM_DATA_W 16
`define SDRAM_REGION_W 3
`define SDRAM_WORD_W 21

// ==============================
// Download stream
// ==============================
`define DL_ADDR_W 25
`define DL_INDEX_W 16
// Index bit 6 marks the slave boot image
`define DL_SLAVE_BIT 6
`define WORM_ADDR_W 13
`define WORM_DATA_W 8

// Region codes in the top address bits
`define ROM_REGION 3'd1
`define RAM_REGION 3'd0

`define CLEAR_WORDS_LOG2 19

`endif

//--- logic/loader_pkg.sv
`include "loader_macros.svh"

package loader_pkg;

    // ==============================
    // SDRAM byte address
    // ==============================

    // Same 25 bits seen either as a flat byte address
    // or split into region, word offset and byte select
    typedef union packed {
        logic [`SDRAM_ADDR_W-1:0] flat;
        struct packed {
            // Top bits pick ROM or RAM
            logic [`SDRAM_REGION_W-1:0] region;
            // 16-bit word index inside the region
            logic [`SDRAM_WORD_W-1:0]   word;
            // Always zero for word accesses
            logic                       byte_sel;
        } fields;
    } sdram_addr_u;

endpackage

//--- logic/boot_control.sv
`timescale 1ns/1ps

module boot_control (
    input  logic clk_sys,
    input  logic arst_n,
    // Configuration register write
    input  logic cfg_wr,
    input  logic soft_reset_in,
    input  logic clear_en_in,
    // Other reset causes
    input  logic user_reset,
    input  logic dl_active,
    input  logic clear_done,
    output logic clear_en,
    output logic core_reset
);

    logic soft_reset;
    logic reset_cause;

    // ==============================
    // Configuration registers
    // ==============================
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            soft_reset <= 1'b0;
            clear_en   <= 1'b0;
        end else if (cfg_wr) begin
            soft_reset <= soft_reset_in;
            clear_en   <= clear_en_in;
        end
    end

    // ==============================
    // Core reset
    // ==============================

    // Core stays in reset while loading or clearing
    assign reset_cause = soft_reset || user_reset || dl_active || !clear_done;

    // High core_reset also means the loader owns SDRAM
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            core_reset <= 1'b1;
        end else begin
            core_reset <= reset_cause;
        end
    end

endmodule

//--- logic/download_router.sv
`timescale 1ns/1ps

`include "loader_macros.svh"

module download_router (
    input  logic                      clk_sys,
    input  logic                      arst_n,
    // Download stream
    input  logic                      dl_valid,
    input  logic [`DL_ADDR_W-1:0]     dl_addr,
    input  logic [`SDRAM_DATA_W-1:0]  dl_data,
    input  logic [`DL_INDEX_W-1:0]    dl_index,
    output logic                      dl_ready,
    // Pending ROM write toward the arbiter
    input  logic                      rom_done,
    output logic                      rom_req,
    output loader_pkg::sdram_addr_u   rom_addr,
    output logic [`SDRAM_DATA_W-1:0]  rom_data,
    // Slave write-once memory port
    output logic [`WORM_ADDR_W-1:0]   worm_addr,
    output logic [`WORM_DATA_W-1:0]   worm_data,
    output logic                      worm_wr
);

    logic                    beat_fire;
    logic                    is_slave;
    logic                    rom_fire;
    logic                    slave_fire;
    // Second byte of a slave beat still owed
    logic                    slave_second;
    logic [`WORM_DATA_W-1:0] second_byte;

    // ==============================
    // Beat steering
    // ==============================
    assign is_slave   = dl_index[`DL_SLAVE_BIT];
    assign beat_fire  = dl_valid && dl_ready;
    assign rom_fire   = beat_fire && !is_slave;
    assign slave_fire = beat_fire && is_slave;

    // Back-pressure while a ROM write waits or a byte is owed
    assign dl_ready = !rom_req && !slave_second;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            rom_req      <= 1'b0;
            slave_second <= 1'b0;
            worm_wr      <= 1'b0;
        end else begin
            if (rom_fire) begin
                rom_req <= 1'b1;
            end else if (rom_done) begin
                rom_req <= 1'b0;
            end

            if (slave_fire) begin
                slave_second <= 1'b1;
                worm_wr      <= 1'b1;
            end else if (slave_second) begin
                slave_second <= 1'b0;
                worm_wr      <= 1'b1;
            end else begin
                worm_wr <= 1'b0;
            end
        end
    end

    // ==============================
    // ROM write payload
    // ==============================

    // Stream is little endian, the core wants big endian words
    always_ff @(posedge clk_sys) begin
        if (rom_fire) begin
            rom_addr.fields.region   <= `ROM_REGION;
            rom_addr.fields.word     <= dl_addr[`SDRAM_WORD_W:1];
            rom_addr.fields.byte_sel <= 1'b0;
            rom_data                 <= {dl_data[7:0], dl_data[15:8]};
        end
    end

    // ==============================
    // Slave byte writes
    // ==============================

    // Low byte first, then the high byte at the odd address
    always_ff @(posedge clk_sys) begin
        if (slave_fire) begin
            worm_addr   <= dl_addr[`WORM_ADDR_W-1:0];
            worm_data   <= dl_data[7:0];
            second_byte <= dl_data[15:8];
        end else if (slave_second) begin
            worm_addr[0] <= 1'b1;
            worm_data    <= second_byte;
        end
    end

endmodule

//--- logic/ram_clear_sequencer.sv
`timescale 1ns/1ps

`include "loader_macros.svh"

module ram_clear_sequencer #(
    parameter int CLEAR_WORDS_LOG2 = `CLEAR_WORDS_LOG2
) (
    input  logic                    clk_sys,
    input  logic                    arst_n,
    input  logic                    dl_active,
    input  logic                    clear_en,
    // One pulse per finished clear write
    input  logic                    clear_step,
    output logic                    clear_req,
    output loader_pkg::sdram_addr_u clear_addr,
    output logic                    clear_done
);

    // Top bit set once every word has been written
    logic [CLEAR_WORDS_LOG2:0] word_cnt;
    logic                      dl_active_q;
    logic                      dl_start;
    logic                      all_cleared;

    assign dl_start    = dl_active && !dl_active_q;
    assign all_cleared = word_cnt[CLEAR_WORDS_LOG2];

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            dl_active_q <= 1'b0;
            word_cnt    <= {1'b1, {CLEAR_WORDS_LOG2{1'b0}}};
        end else begin
            dl_active_q <= dl_active;
            // Rising edge of the download restarts the walk
            if (dl_start && clear_en) begin
                word_cnt <= '0;
            end else if (clear_step && !all_cleared) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    assign clear_req  = clear_en && !all_cleared;
    assign clear_done = !clear_req;

    always_comb begin
        clear_addr.flat          = '0;
        clear_addr.fields.region = `RAM_REGION;
        clear_addr.fields.word[CLEAR_WORDS_LOG2-1:0] = word_cnt[CLEAR_WORDS_LOG2-1:0];
    end

endmodule

//--- logic/sdram_arbiter.sv
`timescale 1ns/1ps

`include "loader_macros.svh"

module sdram_arbiter (
    input  logic                      clk_sys,
    input  logic                      arst_n,
    input  logic                      core_reset,
    // Preparation requests
    input  logic                      rom_req,
    input  loader_pkg::sdram_addr_u   rom_addr,
    input  logic [`SDRAM_DATA_W-1:0]  rom_data,
    input  logic                      clear_req,
    input  loader_pkg::sdram_addr_u   clear_addr,
    output logic                      rom_done,
    output logic                      clear_step,
    // Core requests
    input  logic [`SDRAM_ADDR_W-1:0]  core_addr,
    input  logic [`SDRAM_DATA_W-1:0]  core_din,
    input  logic                      core_rd,
    input  logic                      core_wr,
    input  logic                      core_word,
    input  logic                      core_refresh,
    input  logic                      core_burst,
    // SDRAM controller
    input  logic                      sdram_busy,
    output logic [`SDRAM_ADDR_W-1:0]  sdram_addr,
    output logic [`SDRAM_DATA_W-1:0]  sdram_din,
    output logic                      sdram_rd,
    output logic                      sdram_wr,
    output logic                      sdram_word,
    output logic                      sdram_refresh,
    output logic                      sdram_burst
);

    // Owner encoding with ROM first
    localparam logic [1:0] OWN_IDLE    = 2'd0;
    localparam logic [1:0] OWN_ROM     = 2'd1;
    localparam logic [1:0] OWN_CLEAR   = 2'd2;
    localparam logic [1:0] OWN_REFRESH = 2'd3;

    logic [1:0]                owner;
    logic [1:0]                owner_next;
    logic [1:0]                owner_q;
    logic                      busy_q;
    logic                      access_end;
    loader_pkg::sdram_addr_u   prep_addr;
    logic [`SDRAM_DATA_W-1:0]  prep_din;
    logic                      prep_rd;
    logic                      prep_wr;
    logic                      prep_refresh;

    // ==============================
    // Owner selection
    // ==============================
    always_comb begin
        owner_next = OWN_IDLE;
        if (core_reset) begin
            owner_next = OWN_REFRESH;
            if (clear_req) begin
                owner_next = OWN_CLEAR;
            end
            if (rom_req) begin
                owner_next = OWN_ROM;
            end
        end
        // Keep the owner until the access is over
        owner = sdram_busy ? owner_q : owner_next;
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            owner_q <= OWN_IDLE;
            busy_q  <= 1'b0;
        end else begin
            owner_q <= owner;
            busy_q  <= sdram_busy;
        end
    end

    // Falling edge of busy ends the access
    assign access_end = busy_q && !sdram_busy;
    assign rom_done   = access_end && (owner_q == OWN_ROM);
    assign clear_step = access_end && (owner_q == OWN_CLEAR);

    // ==============================
    // Preparation requests
    // ==============================
    always_comb begin
        prep_addr.flat          = '0;
        prep_addr.fields.region = `RAM_REGION;
        prep_din                = '0;
        prep_rd                 = 1'b0;
        prep_wr                 = 1'b0;
        prep_refresh            = 1'b0;

        case (owner)
            OWN_ROM: begin
                prep_addr = rom_addr;
                prep_din  = rom_data;
                prep_wr   = 1'b1;
            end
            OWN_CLEAR: begin
                prep_addr = clear_addr;
                prep_wr   = 1'b1;
            end
            OWN_REFRESH: begin
                prep_rd      = 1'b1;
                prep_refresh = 1'b1;
            end
            default: begin
            end
        endcase

        // No request in reset, and requesters see their done pulse in the cycle
        // busy fell, so wait one more
        if (!arst_n || sdram_busy || busy_q) begin
            prep_rd      = 1'b0;
            prep_wr      = 1'b0;
            prep_refresh = 1'b0;
        end
    end

    // ==============================
    // Output multiplexer
    // ==============================
    assign sdram_addr    = core_reset ? prep_addr.flat : core_addr;
    assign sdram_din     = core_reset ? prep_din : core_din;
    assign sdram_rd      = core_reset ? prep_rd : core_rd;
    assign sdram_wr      = core_reset ? prep_wr : core_wr;
    assign sdram_word    = core_reset ? 1'b1 : core_word;
    assign sdram_refresh = core_reset ? prep_refresh : core_refresh;
    assign sdram_burst   = core_reset ? 1'b0 : core_burst;

endmodule

//--- logic/loader_top.sv
`timescale 1ns/1ps

`include "loader_macros.svh"

module loader_top #(
    parameter int CLEAR_WORDS_LOG2 = `CLEAR_WORDS_LOG2
) (
    input  logic                      clk_sys,
    input  logic                      arst_n,
    // Download stream
    input  logic                      dl_valid,
    input  logic [`DL_ADDR_W-1:0]     dl_addr,
    input  logic [`SDRAM_DATA_W-1:0]  dl_data,
    input  logic [`DL_INDEX_W-1:0]    dl_index,
    input  logic                      dl_active,
    output logic                      dl_ready,
    // Configuration
    input  logic                      cfg_wr,
    input  logic                      soft_reset_in,
    input  logic                      clear_en_in,
    input  logic                      user_reset,
    // Slave write-once memory
    output logic [`WORM_ADDR_W-1:0]   worm_addr,
    output logic [`WORM_DATA_W-1:0]   worm_data,
    output logic                      worm_wr,
    output logic                      core_reset,
    // Core side
    input  logic [`SDRAM_ADDR_W-1:0]  core_addr,
    input  logic [`SDRAM_DATA_W-1:0]  core_din,
    input  logic                      core_rd,
    input  logic                      core_wr,
    input  logic                      core_word,
    input  logic                      core_refresh,
    input  logic                      core_burst,
    // SDRAM side
    input  logic                      sdram_busy,
    output logic [`SDRAM_ADDR_W-1:0]  sdram_addr,
    output logic [`SDRAM_DATA_W-1:0]  sdram_din,
    output logic                      sdram_rd,
    output logic                      sdram_wr,
    output logic                      sdram_word,
    output logic                      sdram_refresh,
    output logic                      sdram_burst
);

    logic                     clear_en;
    logic                     clear_done;
    logic                     clear_req;
    logic                     clear_step;
    loader_pkg::sdram_addr_u  clear_addr;
    logic                     rom_req;
    logic                     rom_done;
    loader_pkg::sdram_addr_u  rom_addr;
    logic [`SDRAM_DATA_W-1:0] rom_data;

    boot_control i_boot_control (
        .clk_sys       (clk_sys),
        .arst_n        (arst_n),
        .cfg_wr        (cfg_wr),
        .soft_reset_in (soft_reset_in),
        .clear_en_in   (clear_en_in),
        .user_reset    (user_reset),
        .dl_active     (dl_active),
        .clear_done    (clear_done),
        .clear_en      (clear_en),
        .core_reset    (core_reset)
    );

    download_router i_download_router (
        .clk_sys   (clk_sys),
        .arst_n    (arst_n),
        .dl_valid  (dl_valid),
        .dl_addr   (dl_addr),
        .dl_data   (dl_data),
        .dl_index  (dl_index),
        .dl_ready  (dl_ready),
        .rom_done  (rom_done),
        .rom_req   (rom_req),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .worm_addr (worm_addr),
        .worm_data (worm_data),
        .worm_wr   (worm_wr)
    );

    ram_clear_sequencer #(
        .CLEAR_WORDS_LOG2 (CLEAR_WORDS_LOG2)
    ) i_ram_clear_sequencer (
        .clk_sys    (clk_sys),
        .arst_n     (arst_n),
        .dl_active  (dl_active),
        .clear_en   (clear_en),
        .clear_step (clear_step),
        .clear_req  (clear_req),
        .clear_addr (clear_addr),
        .clear_done (clear_done)
    );

    sdram_arbiter i_sdram_arbiter (
        .clk_sys       (clk_sys),
        .arst_n        (arst_n),
        .core_reset    (core_reset),
        .rom_req       (rom_req),
        .rom_addr      (rom_addr),
        .rom_data      (rom_data),
        .clear_req     (clear_req),
        .clear_addr    (clear_addr),
        .rom_done      (rom_done),
        .clear_step    (clear_step),
        .core_addr     (core_addr),
        .core_din      (core_din),
        .core_rd       (core_rd),
        .core_wr       (core_wr),
        .core_word     (core_word),
        .core_refresh  (core_refresh),
        .core_burst    (core_burst),
        .sdram_busy    (sdram_busy),
        .sdram_addr    (sdram_addr),
        .sdram_din     (sdram_din),
        .sdram_rd      (sdram_rd),
        .sdram_wr      (sdram_wr),
        .sdram_word    (sdram_word),
        .sdram_refresh (sdram_refresh),
        .sdram_burst   (sdram_burst)
    );

endmodule

//--- bench/tb_loader_top.sv
`timescale 1ns/1ps

`include "loader_macros.svh"

module tb_loader_top;

    localparam int KIND_ROM   = 0;
    localparam int KIND_SLAVE = 1;
    localparam int KIND_CORE  = 2;
    localparam int CLEAR_LOG2 = 3;
    localparam int WAIT_LIMIT = 200;

    logic                     clk_sys;
    logic                     arst_n;
    logic                     dl_valid;
    logic [`DL_ADDR_W-1:0]    dl_addr;
    logic [`SDRAM_DATA_W-1:0] dl_data;
    logic [`DL_INDEX_W-1:0]   dl_index;
    logic                     dl_active;
    logic                     dl_ready;
    logic                     cfg_wr;
    logic                     soft_reset_in;
    logic                     clear_en_in;
    logic                     user_reset;
    logic [`WORM_ADDR_W-1:0]  worm_addr;
    logic [`WORM_DATA_W-1:0]  worm_data;
    logic                     worm_wr;
    logic                     core_reset;
    logic [`SDRAM_ADDR_W-1:0] core_addr;
    logic [`SDRAM_DATA_W-1:0] core_din;
    logic                     core_rd;
    logic                     core_wr;
    logic                     core_word;
    logic                     core_refresh;
    logic                     core_burst;
    logic                     sdram_busy;
    logic [`SDRAM_ADDR_W-1:0] sdram_addr;
    logic [`SDRAM_DATA_W-1:0] sdram_din;
    logic                     sdram_rd;
    logic                     sdram_wr;
    logic                     sdram_word;
    logic                     sdram_refresh;
    logic                     sdram_burst;

    // Stimulus table with one entry per beat or core request
    int                       tbl_kind[$];
    logic [15:0]              tbl_index[$];
    logic [24:0]              tbl_addr[$];
    logic [15:0]              tbl_data[$];
    logic [24:0]              tbl_exp_addr[$];
    logic [15:0]              tbl_exp_data[$];

    // Preparation writes as {address, data}
    logic [40:0]              prep_writes[$];
    logic [31:0]              rand_state;
    int                       busy_left;
    logic                     req_seen;
    int                       rom_beats;

    loader_top #(
        .CLEAR_WORDS_LOG2 (CLEAR_LOG2)
    ) i_dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    // ==============================
    // Helpers
    // ==============================
    function logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "Mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t after %0d cycles waiting for %s", $time, WAIT_LIMIT, what);
        $display(">>> FAIL");
        $fatal(1, "Timeout");
    endtask

    task automatic add_entry(input int kind, input logic [15:0] index,
                             input logic [24:0] addr, input logic [15:0] data,
                             input logic [24:0] exp_addr, input logic [15:0] exp_data);
        tbl_kind.push_back(kind);
        tbl_index.push_back(index);
        tbl_addr.push_back(addr);
        tbl_data.push_back(data);
        tbl_exp_addr.push_back(exp_addr);
        tbl_exp_data.push_back(exp_data);
    endtask

    // Returns at a falling edge with dl_ready high
    task automatic wait_dl_ready(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk_sys);
        while (!dl_ready && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge clk_sys);
        end
        if (!dl_ready) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_core_reset_low();
        int cycles;
        cycles = 0;
        @(negedge clk_sys);
        while (core_reset && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge clk_sys);
        end
        if (core_reset) begin
            report_timeout("core_reset to fall");
        end
    endtask

    // ==============================
    // SDRAM responder and monitor
    // ==============================
    always @(negedge clk_sys) begin
        req_seen = arst_n && !sdram_busy && (sdram_rd || sdram_wr);
        if (req_seen && core_reset) begin
            check_value("preparation word access", 32'(sdram_word), 32'd1);
            check_value("preparation burst", 32'(sdram_burst), 32'd0);
            if (sdram_wr) begin
                prep_writes.push_back({sdram_addr, sdram_din});
            end else begin
                check_value("idle request refresh", 32'(sdram_refresh), 32'd1);
            end
        end
    end

    // Busy starts the cycle after the request is taken
    always @(posedge clk_sys) begin
        #2;
        if (busy_left > 0) begin
            busy_left = busy_left - 1;
            if (busy_left == 0) begin
                sdram_busy = 1'b0;
            end
        end else if (req_seen) begin
            busy_left  = 1 + int'(next_rand() % 4);
            sdram_busy = 1'b1;
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic apply_beat(input int i);
        int start_idx;
        dl_valid = 1'b1;
        dl_index = tbl_index[i];
        dl_addr  = tbl_addr[i];
        dl_data  = tbl_data[i];
        wait_dl_ready("beat acceptance");
        @(posedge clk_sys);
        #2;
        dl_valid  = 1'b0;
        start_idx = prep_writes.size();
        if (tbl_kind[i] == KIND_SLAVE) begin
            @(negedge clk_sys);
            check_value("dl_ready after slave beat", 32'(dl_ready), 32'd0);
            check_value("first byte strobe", 32'(worm_wr), 32'd1);
            check_value("first byte address", 32'(worm_addr), 32'(tbl_exp_addr[i]));
            check_value("first byte data", 32'(worm_data), 32'(tbl_exp_data[i][7:0]));
            @(negedge clk_sys);
            check_value("second byte strobe", 32'(worm_wr), 32'd1);
            check_value("second byte address", 32'(worm_addr), 32'(tbl_exp_addr[i] | 25'd1));
            check_value("second byte data", 32'(worm_data), 32'(tbl_exp_data[i][15:8]));
            @(negedge clk_sys);
            check_value("strobe after two bytes", 32'(worm_wr), 32'd0);
        end else begin
            // First write after acceptance must be this beat
            wait_dl_ready("end of ROM write");
            check_value("ROM write issued", 32'(prep_writes.size() > start_idx), 32'd1);
            check_value("busy when dl_ready returns", 32'(sdram_busy), 32'd0);
            check_value("ROM write address", 32'(prep_writes[start_idx][40:16]),
                        32'(tbl_exp_addr[i]));
            check_value("ROM write data", 32'(prep_writes[start_idx][15:0]),
                        32'(tbl_exp_data[i]));
            rom_beats++;
        end
        @(posedge clk_sys);
        #2;
    endtask

    task automatic finish_download();
        int          clears;
        int          roms;
        int          k;
        logic [40:0] entry;
        dl_active = 1'b0;
        wait_core_reset_low();
        clears = 0;
        roms   = 0;
        for (k = 0; k < prep_writes.size(); k++) begin
            entry = prep_writes[k];
            check_value("write byte select", 32'(entry[16]), 32'd0);
            if (entry[40:38] == 3'd0) begin
                check_value("clear word offset", 32'(entry[37:17]), clears);
                check_value("clear data", 32'(entry[15:0]), 32'd0);
                clears++;
            end else begin
                check_value("ROM region code", 32'(entry[40:38]), 32'd1);
                roms++;
            end
        end
        check_value("number of clear writes", clears, 1 << CLEAR_LOG2);
        check_value("number of ROM writes", roms, rom_beats);
        @(posedge clk_sys);
        #2;
    endtask

    task automatic apply_core_request(input int i);
        {core_burst, core_refresh, core_word, core_wr, core_rd} = tbl_index[i][4:0];
        core_addr = tbl_addr[i];
        core_din  = tbl_data[i];
        @(negedge clk_sys);
        check_value("core_reset in core phase", 32'(core_reset), 32'd0);
        check_value("passed address", 32'(sdram_addr), 32'(tbl_exp_addr[i]));
        check_value("passed data", 32'(sdram_din), 32'(tbl_exp_data[i]));
        check_value("passed controls",
                    32'({sdram_burst, sdram_refresh, sdram_word, sdram_wr, sdram_rd}),
                    32'(tbl_index[i][4:0]));
        @(posedge clk_sys);
        #2;
    endtask

    initial begin
        int i;
        arst_n        = 1'b0;
        dl_valid      = 1'b0;
        dl_addr       = '0;
        dl_data       = '0;
        dl_index      = '0;
        dl_active     = 1'b0;
        cfg_wr        = 1'b0;
        soft_reset_in = 1'b0;
        clear_en_in   = 1'b0;
        user_reset    = 1'b0;
        core_addr     = '0;
        core_din      = '0;
        core_rd       = 1'b0;
        core_wr       = 1'b0;
        core_word     = 1'b0;
        core_refresh  = 1'b0;
        core_burst    = 1'b0;
        sdram_busy    = 1'b0;
        busy_left     = 0;
        req_seen      = 1'b0;
        rand_state    = 32'd24;
        rom_beats     = 0;

        // Kind, index, address, data, expected address, expected data
        // Core entries carry {burst, refresh, word, wr, rd} in the index
        add_entry(KIND_ROM,   16'h0000, 25'h0000000, 16'h1234, 25'h0400000, 16'h3412);
        add_entry(KIND_ROM,   16'h0000, 25'h0000002, 16'hABCD, 25'h0400002, 16'hCDAB);
        add_entry(KIND_SLAVE, 16'h0040, 25'h0000100, 16'h5A3C, 25'h0000100, 16'h5A3C);
        add_entry(KIND_ROM,   16'h0001, 25'h01FFFFE, 16'h00FF, 25'h05FFFFE, 16'hFF00);
        add_entry(KIND_SLAVE, 16'h0041, 25'h0001FFE, 16'hC001, 25'h0001FFE, 16'hC001);
        add_entry(KIND_SLAVE, 16'hFFC0, 25'h0000A42, 16'h7E81, 25'h0000A42, 16'h7E81);
        add_entry(KIND_ROM,   16'hFF80, 25'h0003456, 16'h8001, 25'h0403456, 16'h0180);
        add_entry(KIND_ROM,   16'h0000, 25'h0000101, 16'h0102, 25'h0400100, 16'h0201);
        add_entry(KIND_CORE,  16'h0005, 25'h0123456, 16'hBEEF, 25'h0123456, 16'hBEEF);
        add_entry(KIND_CORE,  16'h0012, 25'h1FEDCBA, 16'h0F0F, 25'h1FEDCBA, 16'h0F0F);
        add_entry(KIND_CORE,  16'h0009, 25'h0000000, 16'h0000, 25'h0000000, 16'h0000);
        add_entry(KIND_CORE,  16'h0000, 25'h0000ACE, 16'h5555, 25'h0000ACE, 16'h5555);

        // Outputs while reset is held
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("core_reset in reset", 32'(core_reset), 32'd1);
        check_value("sdram_wr in reset", 32'(sdram_wr), 32'd0);
        check_value("sdram_rd in reset", 32'(sdram_rd), 32'd0);
        check_value("worm_wr in reset", 32'(worm_wr), 32'd0);
        check_value("dl_ready in reset", 32'(dl_ready), 32'd1);
        @(posedge clk_sys);
        #2;
        arst_n = 1'b1;
        @(negedge clk_sys);
        check_value("core_reset after reset", 32'(core_reset), 32'd1);
        check_value("sdram_wr after reset", 32'(sdram_wr), 32'd0);
        check_value("worm_wr after reset", 32'(worm_wr), 32'd0);
        wait_core_reset_low();

        // Enable the RAM clear, then open the download
        @(posedge clk_sys);
        #2;
        cfg_wr      = 1'b1;
        clear_en_in = 1'b1;
        @(posedge clk_sys);
        #2;
        cfg_wr    = 1'b0;
        dl_active = 1'b1;
        @(posedge clk_sys);
        #2;
        check_value("core_reset in download", 32'(core_reset), 32'd1);

        for (i = 0; i < tbl_kind.size(); i++) begin
            if (tbl_kind[i] == KIND_CORE) begin
                if (dl_active) begin
                    finish_download();
                end
                apply_core_request(i);
            end else begin
                apply_beat(i);
            end
        end
        if (dl_active) begin
            finish_download();
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+logic
logic/loader_pkg.sv
logic/boot_control.sv
logic/download_router.sv
logic/ram_clear_sequencer.sv
logic/sdram_arbiter.sv
logic/loader_top.sv
bench/tb_loader_top.sv

//--- Makefile
# Verilator build and run for the boot loader testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
		--top-module tb_loader_top -o tb_loader_top

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/tb_loader_top 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
